/* rv32i_types.sv */
// RV32I pipeline slice types

package rv32i_types;

    // ####################################################################
    // Widths
    // ####################################################################

    localparam int xlen = 32;

    // ####################################################################
    // Opcodes and funct3 values
    // ####################################################################

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;

    localparam logic [2:0] funct3_word = 3'b010;
    localparam logic [2:0] funct3_add  = 3'b000;

    // ####################################################################
    // Stall FSM and instruction formats
    // ####################################################################

    // Which memory responses are still awaited.
    typedef enum logic [1:0] {
        idle,
        wait_imem,
        wait_dmem,
        imem_dmem
    } stall_state;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // One instruction word, read as I-type or S-type.
    typedef union packed {
        i_type_t i;
        s_type_t s;
    } rv32i_instr_t;

endpackage

/* mem_port_if.sv */
// Memory port bundle

`timescale 1ns/1ns

interface mem_port_if
    import rv32i_types::*;
();

    // Request side, held stable until resp.
    logic            req;
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;

    // Memory side, resp is a one-cycle pulse.
    logic [xlen-1:0] rdata;
    logic            resp;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, resp
    );

    modport memory (
        input  req, we, addr, wdata,
        output rdata, resp
    );

    modport monitor (
        input req, resp
    );

endinterface

/* stall.sv */
// Pipeline stall controller

`timescale 1ns/1ns

module stall
    import rv32i_types::*;
(
    input  logic clk,
    input  logic rst,

    mem_port_if.monitor imem,
    mem_port_if.monitor dmem,

    output logic move
);

    stall_state curr_state;
    stall_state next_state;

    logic i_pend;
    logic d_pend;

    // A request still open after this cycle.
    assign i_pend = imem.req && !imem.resp;
    assign d_pend = dmem.req && !dmem.resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            curr_state <= idle;
        end else begin
            curr_state <= next_state;
        end
    end

    always_comb begin
        unique case (curr_state)
            idle:      move = !i_pend && !d_pend;
            wait_imem: move = imem.resp;
            wait_dmem: move = dmem.resp;
            imem_dmem: move = imem.resp && dmem.resp;
            default:   move = 1'b0;
        endcase
    end

    always_comb begin
        next_state = curr_state;
        if (move) begin
            // New contents raise their requests while idle.
            next_state = idle;
        end else begin
            unique case (curr_state)
                idle: begin
                    case ({i_pend, d_pend})
                        2'b11:   next_state = imem_dmem;
                        2'b10:   next_state = wait_imem;
                        2'b01:   next_state = wait_dmem;
                        default: next_state = idle;
                    endcase
                end
                imem_dmem: begin
                    if (imem.resp) begin
                        next_state = wait_dmem;
                    end else if (dmem.resp) begin
                        next_state = wait_imem;
                    end
                end
                default: next_state = curr_state;
            endcase
        end
    end

endmodule

/* fetch_stage.sv */
// Instruction fetch stage

`timescale 1ns/1ns

module fetch_stage
    import rv32i_types::*;
#(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic move,

    mem_port_if.requester imem,

    output logic [xlen-1:0] instr,
    output logic [xlen-1:0] instr_pc
);

    logic [xlen-1:0] pc;
    logic            hold_valid;
    logic [xlen-1:0] hold_word;

    // Request the word at pc until it sits in the hold buffer.
    assign imem.req   = !hold_valid;
    assign imem.we    = 1'b0;
    assign imem.addr  = pc;
    assign imem.wdata = '0;

    assign instr    = hold_valid ? hold_word : imem.rdata;
    assign instr_pc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= reset_pc;
            hold_valid <= 1'b0;
        end else if (move) begin
            pc         <= pc + xlen'(4);
            hold_valid <= 1'b0;
        end else if (imem.resp) begin
            // Early word, keep it until the data side is done.
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (imem.resp) begin
            hold_word <= imem.rdata;
        end
    end

endmodule

/* exec_mem_stage.sv */
// Execute and memory stage

`timescale 1ns/1ns

module exec_mem_stage
    import rv32i_types::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            move,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] instr_pc,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,

    mem_port_if.requester dmem,

    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [xlen-1:0] wb_data,
    output logic            retire_valid,
    output logic [xlen-1:0] retire_pc
);

    logic            valid;
    rv32i_instr_t    ir;
    logic [xlen-1:0] pc_q;
    logic            mem_done;
    logic [xlen-1:0] load_buf;

    logic            is_load;
    logic            is_store;
    logic            is_addi;
    logic            writes_rd;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] load_data;

    // ####################################################################
    // Decode
    // ####################################################################

    assign is_load  = ir.i.opcode == op_load && ir.i.funct3 == funct3_word;
    assign is_store = ir.s.opcode == op_store && ir.s.funct3 == funct3_word;
    assign is_addi  = ir.i.opcode == op_imm && ir.i.funct3 == funct3_add;

    assign writes_rd = is_load || is_addi;

    assign imm_i = {{20{ir.i.imm[11]}}, ir.i.imm};
    assign imm_s = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};

    assign rs1_addr = ir.i.rs1;
    assign rs2_addr = ir.s.rs2;

    assign sum = rs1_data + (is_store ? imm_s : imm_i);

    // ####################################################################
    // Data port
    // ####################################################################

    // One access per instruction, dropped once answered.
    assign dmem.req   = valid && (is_load || is_store) && !mem_done;
    assign dmem.we    = is_store;
    assign dmem.addr  = sum;
    assign dmem.wdata = rs2_data;

    assign load_data = mem_done ? load_buf : dmem.rdata;

    // ####################################################################
    // Retire
    // ####################################################################

    assign retire_valid = move && valid;
    assign retire_pc    = pc_q;

    assign wb_en   = retire_valid && writes_rd;
    assign wb_addr = writes_rd ? ir.i.rd : 5'd0;
    assign wb_data = is_load ? load_data : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            mem_done <= 1'b0;
        end else if (move) begin
            valid    <= 1'b1;
            mem_done <= 1'b0;
        end else if (dmem.resp) begin
            mem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            ir   <= instr;
            pc_q <= instr_pc;
        end
        if (dmem.resp) begin
            load_buf <= dmem.rdata;
        end
    end

endmodule

/* regfile.sv */
// Integer register file

`timescale 1ns/1ns

module regfile
    import rv32i_types::*;
(
    input  logic            clk,

    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,

    input  logic            wb_en,
    input  logic [4:0]      wb_addr,
    input  logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] regs [32];

    // x0 reads as zero.
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (wb_en && wb_addr != 5'd0) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

/* core_pipe_top.sv */
// Two-stage pipeline top

`timescale 1ns/1ns

module core_pipe_top
    import rv32i_types::*;
#(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst,

    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_rdata,
    input  logic            imem_resp,

    output logic            dmem_req,
    output logic            dmem_we,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    input  logic [xlen-1:0] dmem_rdata,
    input  logic            dmem_resp,

    output logic            retire_valid,
    output logic [xlen-1:0] retire_pc,
    output logic [4:0]      retire_rd,
    output logic [xlen-1:0] retire_value
);

    logic            move;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] instr_pc;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            wb_en;
    logic [4:0]      wb_addr;
    logic [xlen-1:0] wb_data;

    mem_port_if imem_if ();
    mem_port_if dmem_if ();

    // ####################################################################
    // Memory ports
    // ####################################################################

    assign imem_req      = imem_if.req;
    assign imem_addr     = imem_if.addr;
    assign imem_if.rdata = imem_rdata;
    assign imem_if.resp  = imem_resp;

    assign dmem_req      = dmem_if.req;
    assign dmem_we       = dmem_if.we;
    assign dmem_addr     = dmem_if.addr;
    assign dmem_wdata    = dmem_if.wdata;
    assign dmem_if.rdata = dmem_rdata;
    assign dmem_if.resp  = dmem_resp;

    // Retire shows the write-back.
    assign retire_rd    = wb_addr;
    assign retire_value = wb_data;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch_stage (
        .clk      (clk),
        .rst      (rst),
        .move     (move),
        .imem     (imem_if.requester),
        .instr    (instr),
        .instr_pc (instr_pc)
    );

    exec_mem_stage u_exec_mem_stage (
        .clk          (clk),
        .rst          (rst),
        .move         (move),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .dmem         (dmem_if.requester),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc)
    );

    regfile u_regfile (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    stall u_stall (
        .clk  (clk),
        .rst  (rst),
        .imem (imem_if.monitor),
        .dmem (dmem_if.monitor),
        .move (move)
    );

endmodule

/* tb_mem_model.sv */
// Memory model with random latency

`timescale 1ns/1ns

module tb_mem_model
    import rv32i_types::*;
#(
    parameter int depth       = 256,
    parameter int drive_delay = 10
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  logic            we,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    input  logic [2:0]      latency,
    output logic [xlen-1:0] rdata,
    output logic            resp
);

    logic [xlen-1:0] mem [depth];

    logic busy;
    int   remaining;
    int   idx;
    logic seen_rst;
    logic seen_req;
    logic seen_resp;

    // Sample the ending cycle at the edge, then drive the next one.
    initial begin
        rdata     = '0;
        resp      = 1'b0;
        busy      = 1'b0;
        remaining = 0;
        idx       = 0;
        forever begin
            @(posedge clk);
            seen_rst  = (rst === 1'b1);
            seen_req  = (req === 1'b1);
            seen_resp = resp;
            #drive_delay;
            resp = 1'b0;
            if (seen_rst) begin
                busy = 1'b0;
            end else if (seen_req && !seen_resp) begin
                if (!busy) begin
                    busy      = 1'b1;
                    remaining = int'(latency);
                end
                if (remaining <= 1) begin
                    idx   = int'(addr >> 2) % depth;
                    rdata = mem[idx];
                    // Writes land in the response cycle.
                    if (we === 1'b1) begin
                        mem[idx] = wdata;
                    end
                    resp = 1'b1;
                    busy = 1'b0;
                end else begin
                    remaining = remaining - 1;
                end
            end
        end
    end

endmodule

/* tb_core_pipe.sv */
// Pipeline slice testbench

`timescale 1ns/1ns

module tb_core_pipe
    import rv32i_types::*;
;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam int imem_depth     = 256;
    localparam int dmem_depth     = 256;
    localparam int drive_delay    = 10;
    localparam int prog_len       = 38;
    localparam int total_retires  = prog_len + 8;
    localparam int retire_timeout = 40;

    logic            clk = 1'b0;
    logic            rst;
    logic            imem_req;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_rdata;
    logic            imem_resp;
    logic            dmem_req;
    logic            dmem_we;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic [xlen-1:0] dmem_rdata;
    logic            dmem_resp;
    logic            retire_valid;
    logic [xlen-1:0] retire_pc;
    logic [4:0]      retire_rd;
    logic [xlen-1:0] retire_value;
    logic [2:0]      imem_latency;
    logic [2:0]      dmem_latency;

    // Reference state advances once per retirement.
    logic [xlen-1:0] program_words [imem_depth];
    logic [xlen-1:0] ref_mem [dmem_depth];
    logic [xlen-1:0] ref_regs [32];
    logic [xlen-1:0] expected_pc      = reset_pc;
    int              retire_count     = 0;
    logic            first_fetch_seen = 1'b0;

    // Previous sample for the stability checks.
    logic            rst_prev   = 1'b1;
    logic            prev_ireq  = 1'b0;
    logic            prev_iresp = 1'b0;
    logic [xlen-1:0] prev_iaddr = '0;
    logic            prev_dreq  = 1'b0;
    logic            prev_dresp = 1'b0;
    logic            prev_dwe   = 1'b0;
    logic [xlen-1:0] prev_daddr = '0;
    logic [xlen-1:0] prev_dwdata = '0;

    core_pipe_top #(
        .reset_pc (reset_pc)
    ) u_core_pipe_top (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .dmem_req     (dmem_req),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    tb_mem_model #(
        .depth       (imem_depth),
        .drive_delay (drive_delay)
    ) u_imem (
        .clk     (clk),
        .rst     (rst),
        .req     (imem_req),
        .we      (1'b0),
        .addr    (imem_addr),
        .wdata   ('0),
        .latency (imem_latency),
        .rdata   (imem_rdata),
        .resp    (imem_resp)
    );

    tb_mem_model #(
        .depth       (dmem_depth),
        .drive_delay (drive_delay)
    ) u_dmem (
        .clk     (clk),
        .rst     (rst),
        .req     (dmem_req),
        .we      (dmem_we),
        .addr    (dmem_addr),
        .wdata   (dmem_wdata),
        .latency (dmem_latency),
        .rdata   (dmem_rdata),
        .resp    (dmem_resp)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // Fresh latencies each cycle from one seeded stream.
    initial begin : latency_draw
        int unsigned seed;
        seed         = 32'hac6f_8d77;
        imem_latency = 3'd1;
        dmem_latency = 3'd1;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            imem_latency = 3'($urandom_range(4, 1));
            dmem_latency = 3'($urandom_range(4, 1));
        end
    end

    // ####################################################################
    // Helpers
    // ####################################################################

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [xlen-1:0] encode_i(input logic [6:0] opcode,
                                                 input logic [2:0] funct3,
                                                 input logic [4:0] rd,
                                                 input logic [4:0] rs1,
                                                 input int imm);
        rv32i_instr_t w;
        w.i.imm    = imm[11:0];
        w.i.rs1    = rs1;
        w.i.funct3 = funct3;
        w.i.rd     = rd;
        w.i.opcode = opcode;
        return w;
    endfunction

    function automatic logic [xlen-1:0] encode_sw(input logic [4:0] rs2,
                                                  input logic [4:0] rs1,
                                                  input int imm);
        rv32i_instr_t w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = funct3_word;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = op_store;
        return w;
    endfunction

    function automatic logic [xlen-1:0] data_fill(input int idx);
        return 32'(idx) * 32'h9e37_79b9 + 32'h1357_2468;
    endfunction

    function automatic int data_index(input logic [xlen-1:0] addr);
        return int'(addr >> 2) % dmem_depth;
    endfunction

    task automatic load_program();
        int k;
        // Opcode zero words are no-ops that carry their own index.
        for (int i = 0; i < imem_depth; i++) begin
            program_words[i] = {25'(i), 7'b0000000};
        end
        program_words[0]  = encode_i(op_imm, funct3_add, 5'd1, 5'd0, 64);
        program_words[1]  = encode_i(op_imm, funct3_add, 5'd2, 5'd0, -5);
        program_words[2]  = encode_sw(5'd2, 5'd1, 8);
        program_words[3]  = encode_i(op_load, funct3_word, 5'd3, 5'd1, 8);
        program_words[4]  = encode_i(op_imm, funct3_add, 5'd4, 5'd3, 100);
        program_words[5]  = encode_i(op_load, funct3_word, 5'd5, 5'd1, 0);
        program_words[6]  = encode_i(op_imm, funct3_add, 5'd0, 5'd4, 7);
        program_words[7]  = encode_sw(5'd4, 5'd1, -4);
        program_words[9]  = encode_i(op_load, funct3_word, 5'd6, 5'd1, -4);
        program_words[10] = encode_i(op_imm, funct3_add, 5'd7, 5'd6, -2048);
        program_words[11] = encode_sw(5'd5, 5'd1, 12);
        program_words[12] = encode_i(op_load, funct3_word, 5'd8, 5'd1, 12);
        program_words[13] = encode_i(op_imm, funct3_add, 5'd9, 5'd8, 1);
        for (k = 0; k < 8; k++) begin
            program_words[14 + 3 * k] = encode_sw(5'd9, 5'd1, 16 + 4 * k);
            program_words[15 + 3 * k] = encode_i(op_load, funct3_word, 5'd11, 5'd1, 16 + 4 * k);
            program_words[16 + 3 * k] = encode_i(op_imm, funct3_add, 5'd9, 5'd11, k + 1);
        end
        for (int i = 0; i < imem_depth; i++) begin
            u_imem.mem[i] = program_words[i];
        end
        for (int i = 0; i < dmem_depth; i++) begin
            u_dmem.mem[i] = data_fill(i);
            ref_mem[i]    = data_fill(i);
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
    endtask

    // ####################################################################
    // Per-cycle checks at the falling edge
    // ####################################################################

    task automatic check_cycle();
        rv32i_instr_t    w;
        logic            is_addi;
        logic            is_load;
        logic            is_store;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] imm_s;
        logic [xlen-1:0] value;
        int              idx;

        idx      = int'((expected_pc - reset_pc) >> 2) % imem_depth;
        w        = program_words[idx];
        is_addi  = w.i.opcode == op_imm && w.i.funct3 == funct3_add;
        is_load  = w.i.opcode == op_load && w.i.funct3 == funct3_word;
        is_store = w.s.opcode == op_store && w.s.funct3 == funct3_word;
        rs1_val  = ref_regs[w.i.rs1];
        rs2_val  = ref_regs[w.s.rs2];
        imm_i    = xlen'($signed(w.i.imm));
        imm_s    = xlen'($signed({w.s.imm_hi, w.s.imm_lo}));

        if (rst || rst_prev) begin
            check_value("reset_retire_valid", 0, 32'(retire_valid));
            check_value("reset_dmem_req", 0, 32'(dmem_req));
        end else begin
            if (!first_fetch_seen && imem_req === 1'b1) begin
                check_value("first_fetch_addr", reset_pc, imem_addr);
                first_fetch_seen = 1'b1;
            end

            // Open requests hold still until answered.
            if (prev_ireq && !prev_iresp) begin
                check_value("imem_req_held", 1, 32'(imem_req));
                check_value("imem_addr_held", prev_iaddr, imem_addr);
            end
            if (prev_dreq && !prev_dresp) begin
                check_value("dmem_req_held", 1, 32'(dmem_req));
                check_value("dmem_we_held", 32'(prev_dwe), 32'(dmem_we));
                check_value("dmem_addr_held", prev_daddr, dmem_addr);
                check_value("dmem_wdata_held", prev_dwdata, dmem_wdata);
            end

            if (dmem_req === 1'b1) begin
                if (is_store) begin
                    check_value("sw_we", 1, 32'(dmem_we));
                    check_value("sw_addr", rs1_val + imm_s, dmem_addr);
                    check_value("sw_wdata", rs2_val, dmem_wdata);
                end else if (is_load) begin
                    check_value("lw_we", 0, 32'(dmem_we));
                    check_value("lw_addr", rs1_val + imm_i, dmem_addr);
                end else begin
                    $display("Data request raised by an instruction that is no load or store");
                    stop_with_failure();
                end
            end

            if ((imem_req === 1'b1 && imem_resp !== 1'b1) ||
                (dmem_req === 1'b1 && dmem_resp !== 1'b1)) begin
                check_value("stall_retire_valid", 0, 32'(retire_valid));
            end

            if (retire_valid === 1'b1) begin
                check_value("retire_pc", expected_pc, retire_pc);
                if (is_addi) begin
                    value = rs1_val + imm_i;
                    check_value("addi_rd", 32'(w.i.rd), 32'(retire_rd));
                    check_value("addi_value", value, retire_value);
                    if (w.i.rd != 5'd0) begin
                        ref_regs[w.i.rd] = value;
                    end
                end else if (is_load) begin
                    value = ref_mem[data_index(rs1_val + imm_i)];
                    check_value("lw_rd", 32'(w.i.rd), 32'(retire_rd));
                    check_value("lw_value", value, retire_value);
                    if (w.i.rd != 5'd0) begin
                        ref_regs[w.i.rd] = value;
                    end
                end else if (is_store) begin
                    check_value("sw_rd", 0, 32'(retire_rd));
                    ref_mem[data_index(rs1_val + imm_s)] = rs2_val;
                end else begin
                    check_value("nop_rd", 0, 32'(retire_rd));
                end
                expected_pc  = expected_pc + 32'd4;
                retire_count = retire_count + 1;
            end
        end

        rst_prev    = rst;
        prev_ireq   = (imem_req === 1'b1);
        prev_iresp  = (imem_resp === 1'b1);
        prev_iaddr  = imem_addr;
        prev_dreq   = (dmem_req === 1'b1);
        prev_dresp  = (dmem_resp === 1'b1);
        prev_dwe    = dmem_we;
        prev_daddr  = dmem_addr;
        prev_dwdata = dmem_wdata;
    endtask

    always @(negedge clk) begin
        check_cycle();
    end

    // ####################################################################
    // Main sequence
    // ####################################################################

    initial begin : run_test
        int wait_cycles;
        int last_count;
        rst = 1'b1;
        load_program();
        repeat (16) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        while (retire_count < total_retires) begin
            last_count  = retire_count;
            wait_cycles = 0;
            while (retire_count == last_count) begin
                @(posedge clk);
                wait_cycles = wait_cycles + 1;
                if (wait_cycles > retire_timeout) begin
                    $display("Pipeline stopped retiring, next pc 0x%08h", expected_pc);
                    stop_with_failure();
                end
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* files.f */
rv32i_types.sv
mem_port_if.sv
stall.sv
fetch_stage.sv
exec_mem_stage.sv
regfile.sv
core_pipe_top.sv
tb_mem_model.sv
tb_core_pipe.sv

/* Bender.yml */
package:
  name: core_pipe

sources:
  - rv32i_types.sv
  - mem_port_if.sv
  - stall.sv
  - fetch_stage.sv
  - exec_mem_stage.sv
  - regfile.sv
  - core_pipe_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_core_pipe.sv
